// ==== sim.f ====
mma_pkg.sv
mma_weight_bank.sv
mma_ia_stage.sv
mma_dot_array.sv
mma_requant.sv
mma_top.sv
tb_mma_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the mma_top testbench with Verilator.
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mma_top -f sim.f -o tb_mma_top > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "build failed"
  exit 1
fi

./obj_dir/tb_mma_top > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" "$SIM_LOG"; then
  exit 1
fi
exit 0

// ==== tb_mma_top.sv ====
// self-checking testbench for mma_top; zero-points kept within +/-100 so adjusted elements fit
`timescale 1ns/10ps
`default_nettype none

module tb_mma_top
  import mma_pkg::*;
;

  localparam int LATENCY       = 5;
  localparam int TOTAL_VECTORS = 84;   // 8 + 16 + 24 + 16 + 20
  localparam int MARGIN_NS     = 5000; // reset, idle test, weight loads, drains

  logic                    clk;
  logic                    rst;
  logic signed [ACC_W-1:0] lhs_zp;
  logic signed [ACC_W-1:0] rhs_zp;
  logic signed [ACC_W-1:0] dst_zp;
  logic signed [ACC_W-1:0] q_mult;
  logic [SHIFT_W-1:0]      q_shift;
  logic signed [ACC_W-1:0] act_min;
  logic signed [ACC_W-1:0] act_max;
  logic                    w_load;
  lane_t                   w_row;
  logic signed [W_W-1:0]   w_data [LANES];
  logic signed [ACC_W-1:0] w_bias;
  logic                    ia_valid;
  logic signed [IA_W-1:0]  ia_data [LANES];
  logic                    out_valid;
  logic signed [OUT_W-1:0] out_data [LANES];

  // shadow copy of the weight matrix, raw values before rhs_zp
  logic signed [W_W-1:0]   w_ref [LANES][LANES];
  logic signed [ACC_W-1:0] b_ref [LANES];

  logic [LANES*OUT_W-1:0] exp_q [$];
  int                     tag_q [$];
  int                     cyc = 0;
  int                     errors = 0;
  int                     checks = 0;
  int                     n_out = 0;
  int                     hit_lo = 0;
  int                     hit_hi = 0;
  int                     test_no = 0;
  int                     err_base = 0;
  logic [31:0]            lcg_state = 32'h9c4108e8;

  mma_top uut (
    .clk(clk), .rst(rst),
    .lhs_zp(lhs_zp), .rhs_zp(rhs_zp), .dst_zp(dst_zp), .q_mult(q_mult),
    .q_shift(q_shift), .act_min(act_min), .act_max(act_max),
    .w_load(w_load), .w_row(w_row), .w_data(w_data), .w_bias(w_bias),
    .ia_valid(ia_valid), .ia_data(ia_data),
    .out_valid(out_valid), .out_data(out_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  always @(posedge clk) cyc <= cyc + 1;

  // ====================
  // random numbers
  // ====================
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_below(input int n);
    return int'((lcg_next() >> 8) % n); // upper bits, better period
  endfunction

  function automatic int rand_range(input int lim);
    return rand_below(2 * lim + 1) - lim;
  endfunction

  // ====================
  // reference model
  // ====================
  function automatic logic [LANES*OUT_W-1:0] model_out(input logic [LANES*IA_W-1:0] ia_p);
    int acc;
    int a_adj;
    int w_adj;
    int res;
    longint p;
    logic [LANES*OUT_W-1:0] o;
    for (int r = 0; r < LANES; r++) begin
      acc = b_ref[r];
      for (int j = 0; j < LANES; j++) begin
        a_adj = int'($signed(ia_p[IA_W*j +: IA_W])) + lhs_zp;
        w_adj = int'(w_ref[r][j]) + rhs_zp;
        acc = acc + a_adj * w_adj; // 32-bit wrap
      end
      p = longint'(acc) * longint'(q_mult);
      if (q_shift > 0) p = p + (longint'(1) << (q_shift - 1));
      p = p >>> q_shift;
      res = int'(p) + dst_zp;
      if (res < act_min) res = act_min;
      if (res > act_max) res = act_max;
      if (res > 127) res = 127;
      if (res < -128) res = -128;
      o[OUT_W*r +: OUT_W] = res[OUT_W-1:0];
    end
    return o;
  endfunction

  // ====================
  // monitor and checks
  // ====================
  always @(posedge clk) begin : monitor
    logic [LANES*OUT_W-1:0] got;
    logic [LANES*OUT_W-1:0] exp_v;
    logic [LANES*IA_W-1:0]  ia_p;
    int                     tag;
    if (!rst && out_valid) begin
      for (int r = 0; r < LANES; r++) got[OUT_W*r +: OUT_W] = out_data[r];
      assert (exp_q.size() > 0) else begin
        errors++;
        $display("out_valid fired at %0t with no vector in flight", $time);
      end
      if (exp_q.size() > 0) begin
        exp_v = exp_q.pop_front();
        tag   = tag_q.pop_front();
        n_out++;
        checks++;
        assert (got == exp_v) else begin
          errors++;
          $display("Mismatch at %0t: out_data %h, expected %h", $time, got, exp_v);
        end
        assert (cyc - tag == LATENCY) else begin
          errors++;
          $display("output at %0t came %0d cycles after its vector instead of %0d",
                   $time, cyc - tag, LATENCY);
        end
        for (int r = 0; r < LANES; r++) begin
          if ($signed(got[OUT_W*r +: OUT_W]) == act_min) hit_lo++;
          if ($signed(got[OUT_W*r +: OUT_W]) == act_max) hit_hi++;
        end
      end
    end
    if (!rst && ia_valid) begin
      for (int j = 0; j < LANES; j++) ia_p[IA_W*j +: IA_W] = ia_data[j];
      exp_q.push_back(model_out(ia_p));
      tag_q.push_back(cyc);
    end
  end

  // ====================
  // stimulus tasks
  // ====================
  task automatic set_config(input int lzp, input int rzp, input int dzp, input int mult,
                            input int shift, input int amin, input int amax);
    @(posedge clk);
    lhs_zp  <= lzp;
    rhs_zp  <= rzp;
    dst_zp  <= dzp;
    q_mult  <= mult;
    q_shift <= SHIFT_W'(shift);
    act_min <= amin;
    act_max <= amax;
  endtask

  task automatic load_weights(input int lim_w, input int lim_b);
    int v;
    for (int r = 0; r < LANES; r++) begin
      @(posedge clk);
      w_load <= 1'b1;
      w_row  <= lane_t'(r);
      for (int j = 0; j < LANES; j++) begin
        v = rand_range(lim_w);
        w_ref[r][j] = v[W_W-1:0];
        w_data[j] <= v[W_W-1:0];
      end
      b_ref[r] = rand_range(lim_b);
      w_bias  <= b_ref[r];
    end
    @(posedge clk);
    w_load <= 1'b0;
  endtask

  task automatic send_vectors(input int n, input int lim, input bit gaps);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      ia_valid <= 1'b1;
      for (int j = 0; j < LANES; j++) ia_data[j] <= IA_W'(rand_range(lim));
      if (gaps && rand_below(2) == 1) begin
        @(posedge clk);
        ia_valid <= 1'b0;
      end
    end
    @(posedge clk);
    ia_valid <= 1'b0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    repeat (2) @(posedge clk); // last vector reaches the monitor first
    while (exp_q.size() > 0 && n < 4 * LATENCY) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() > 0) begin
      errors++;
      $display("%0d outputs never arrived by %0t", exp_q.size(), $time);
    end
  endtask

  task automatic report_test(input string name);
    test_no++;
    $display("test %0d %s: %0d errors", test_no, name, errors - err_base);
    err_base = errors;
  endtask

  // ====================
  // test sequence
  // ====================
  initial begin
    int out_base;
    int shift;
    rst = 1'b1;
    lhs_zp = 0;
    rhs_zp = 0;
    dst_zp = 0;
    q_mult = 1;
    q_shift = '0;
    act_min = -1000;
    act_max = 1000;
    w_load = 1'b0;
    w_row = '0;
    w_bias = 0;
    ia_valid = 1'b0;
    for (int j = 0; j < LANES; j++) begin
      w_data[j] = '0;
      ia_data[j] = '0;
    end
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    repeat (10) begin // nothing sent, nothing out
      @(posedge clk);
      assert (out_valid == 1'b0) else begin
        errors++;
        $display("out_valid high at %0t before any vector", $time);
      end
    end
    report_test("idle after reset");

    set_config(0, 0, 0, 1, 0, -1000, 1000);
    load_weights(3, 20);
    send_vectors(8, 10, 1'b1);
    drain();
    report_test("identity scaling");

    // all three offsets nonzero
    set_config(1 + rand_below(100), -1 - rand_below(100), 1 + rand_below(50), 1, 10,
               -1000, 1000);
    load_weights(127, 5000); // rhs_zp is folded in at load
    send_vectors(16, 127, 1'b1);
    drain();
    report_test("zero-points");

    repeat (4) begin
      shift = 1 + rand_below(12);
      // |q_mult| up to 2^shift keeps most results inside s8, so the rounding bit shows
      set_config(rand_range(8), rand_range(8), rand_range(10), rand_range(1 << shift),
                 shift, -1000, 1000);
      load_weights(8, 50);
      send_vectors(6, 8, 1'b1);
      drain();
    end
    report_test("multiply and rounding shift");

    set_config(0, 0, 0, 1, 4, -20, 30);
    load_weights(127, 100);
    hit_lo = 0;
    hit_hi = 0;
    send_vectors(16, 127, 1'b1);
    drain();
    assert (hit_lo > 0 && hit_hi > 0) else begin
      errors++;
      $display("clamp limits not both reached, low %0d high %0d", hit_lo, hit_hi);
    end
    report_test("activation clamp");

    set_config(5, -3, 2, 77, 6, -128, 127);
    load_weights(127, 1000);
    out_base = n_out;
    send_vectors(20, 127, 1'b0);
    drain();
    assert (n_out - out_base == 20) else begin
      errors++;
      $display("back-to-back run gave %0d outputs for 20 vectors", n_out - out_base);
    end
    report_test("back-to-back stream");

    $display("tests %0d, checks %0d, errors %0d", test_no, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // ====================
  // watchdog
  // ====================
  initial begin
    #(TOTAL_VECTORS * 40 + MARGIN_NS);
    $display("timeout: the run did not finish within %0d ns", TOTAL_VECTORS * 40 + MARGIN_NS);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== mma_top.sv ====
// 5-cycle fixed latency, no back-pressure; load weights only while no vector is in flight
`timescale 1ns/10ps
`default_nettype none

module mma_top
  import mma_pkg::*;
(
  input  wire                       clk,
  input  wire                       rst,
  // level configuration
  input  logic signed [ACC_W-1:0]   lhs_zp,
  input  logic signed [ACC_W-1:0]   rhs_zp,
  input  logic signed [ACC_W-1:0]   dst_zp,
  input  logic signed [ACC_W-1:0]   q_mult,
  input  logic [SHIFT_W-1:0]        q_shift,
  input  logic signed [ACC_W-1:0]   act_min,
  input  logic signed [ACC_W-1:0]   act_max,
  // weight rows
  input  wire                       w_load,
  input  lane_t                     w_row,
  input  logic signed [W_W-1:0]     w_data [LANES],
  input  logic signed [ACC_W-1:0]   w_bias,
  // activation stream
  input  wire                       ia_valid,
  input  logic signed [IA_W-1:0]    ia_data [LANES],
  output logic                      out_valid,
  output logic signed [OUT_W-1:0]   out_data [LANES]
);

  adj_vec_t                w_adj [LANES];
  logic signed [ACC_W-1:0] bias [LANES];
  logic                    adj_valid;
  adj_vec_t                adj_data;
  logic                    dot_valid;
  logic signed [ACC_W-1:0] dot [LANES];

  // ====================
  // weight storage
  // ====================
  mma_weight_bank u_weight_bank (
    .clk    (clk),
    .rst    (rst),
    .w_load (w_load),
    .w_row  (w_row),
    .w_data (w_data),
    .w_bias (w_bias),
    .rhs_zp (rhs_zp),
    .w_adj  (w_adj),
    .bias   (bias)
  );

  // ====================
  // datapath, 1 + 2 + 2 cycles
  // ====================
  mma_ia_stage u_ia_stage (
    .clk       (clk),
    .rst       (rst),
    .ia_valid  (ia_valid),
    .ia_data   (ia_data),
    .lhs_zp    (lhs_zp),
    .adj_valid (adj_valid),
    .adj_data  (adj_data)
  );

  mma_dot_array u_dot_array (
    .clk       (clk),
    .rst       (rst),
    .adj_valid (adj_valid),
    .adj_data  (adj_data),
    .w_adj     (w_adj),
    .dot_valid (dot_valid),
    .dot       (dot)
  );

  mma_requant u_requant (
    .clk       (clk),
    .rst       (rst),
    .dot_valid (dot_valid),
    .dot       (dot),
    .bias      (bias),     // bank is static while streaming
    .q_mult    (q_mult),
    .q_shift   (q_shift),
    .dst_zp    (dst_zp),
    .act_min   (act_min),
    .act_max   (act_max),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

endmodule

`default_nettype wire

// ==== mma_requant.sv ====
// per-tensor scaling only; q_mult, q_shift, dst_zp and the clamp range are held static
`timescale 1ns/10ps
`default_nettype none

module mma_requant
  import mma_pkg::*;
(
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       dot_valid,
  input  logic signed [ACC_W-1:0]   dot [LANES],
  input  logic signed [ACC_W-1:0]   bias [LANES],
  input  logic signed [ACC_W-1:0]   q_mult,
  input  logic [SHIFT_W-1:0]        q_shift,   // N means >> N
  input  logic signed [ACC_W-1:0]   dst_zp,
  input  logic signed [ACC_W-1:0]   act_min,
  input  logic signed [ACC_W-1:0]   act_max,
  output logic                      out_valid,
  output logic signed [OUT_W-1:0]   out_data [LANES]
);

  logic signed [ACC_W-1:0]  biased [LANES];
  logic signed [PROD_W-1:0] prod_q [LANES];
  logic                     prod_valid;
  logic signed [PROD_W-1:0] rnd;              // half an lsb of the result
  logic signed [PROD_W-1:0] shifted [LANES];
  logic signed [ACC_W-1:0]  res [LANES];

  // ====================
  // stage 1, bias and multiply
  // ====================
  always_comb begin
    for (int r = 0; r < LANES; r++) begin
      biased[r] = dot[r] + bias[r]; // wraps at 32 bits
    end
  end

  always_ff @(posedge clk) begin
    if (dot_valid) begin
      for (int r = 0; r < LANES; r++) begin
        prod_q[r] <= PROD_W'(biased[r]) * PROD_W'(q_mult); // full precision
      end
    end
  end

  // ====================
  // stage 2, shift, offset, clamp
  // ====================
  always_comb begin
    rnd = (q_shift != '0) ? (PROD_W'(1) << (q_shift - 1'b1)) : '0;
    for (int r = 0; r < LANES; r++) begin
      shifted[r] = (prod_q[r] + rnd) >>> q_shift;
      res[r]     = ACC_W'(shifted[r]) + dst_zp;
      // user activation range first
      if (res[r] < act_min) res[r] = act_min;
      if (res[r] > act_max) res[r] = act_max;
      // then the s8 limits
      if (res[r] > OUT_MAX) res[r] = OUT_MAX;
      if (res[r] < OUT_MIN) res[r] = OUT_MIN;
    end
  end

  always_ff @(posedge clk) begin
    if (prod_valid) begin
      for (int r = 0; r < LANES; r++) begin
        out_data[r] <= OUT_W'(res[r]); // already within s8
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      prod_valid <= 1'b0;
      out_valid  <= 1'b0;
    end else begin
      prod_valid <= dot_valid;
      out_valid  <= prod_valid;
    end
  end

endmodule

`default_nettype wire

// ==== mma_dot_array.sv ====
// two fixed stages with no stall; weights must not change while a vector is inside
`timescale 1ns/10ps
`default_nettype none

module mma_dot_array
  import mma_pkg::*;
(
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     adj_valid,
  input  adj_vec_t                adj_data,
  input  adj_vec_t                w_adj [LANES],
  output logic                    dot_valid,
  output logic signed [ACC_W-1:0] dot [LANES] // element r is channel r
);

  // one product per channel and lane
  logic signed [ACC_W-1:0] prod_q [LANES][LANES];
  logic                    prod_valid;
  logic signed [ACC_W-1:0] lane_sum [LANES];

  // ====================
  // stage 1, products
  // ====================
  always_ff @(posedge clk) begin
    if (adj_valid) begin
      for (int r = 0; r < LANES; r++) begin
        for (int j = 0; j < LANES; j++) begin
          prod_q[r][j] <= ACC_W'(adj_data[j]) * ACC_W'(w_adj[r][j]);
        end
      end
    end
  end

  // per-channel adder tree over the registered products
  always_comb begin
    for (int r = 0; r < LANES; r++) begin
      lane_sum[r] = '0;
      for (int j = 0; j < LANES; j++) begin
        lane_sum[r] = lane_sum[r] + prod_q[r][j]; // 32-bit wrap
      end
    end
  end

  // ====================
  // stage 2, lane sum
  // ====================
  always_ff @(posedge clk) begin
    if (prod_valid) begin
      for (int r = 0; r < LANES; r++) begin
        dot[r] <= lane_sum[r];
      end
    end
  end

  // valid follows the data through both registers
  always_ff @(posedge clk) begin
    if (rst) begin
      prod_valid <= 1'b0;
      dot_valid  <= 1'b0;
    end else begin
      prod_valid <= adj_valid;
      dot_valid  <= prod_valid;
    end
  end

endmodule

`default_nettype wire

// ==== mma_ia_stage.sv ====
// accepts one vector per cycle with no stall; lhs_zp must stay stable while vectors flow
`timescale 1ns/10ps
`default_nettype none

module mma_ia_stage
  import mma_pkg::*;
(
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     ia_valid,        // one strobe per vector
  input  logic signed [IA_W-1:0]  ia_data [LANES],
  input  logic signed [ACC_W-1:0] lhs_zp,
  output logic                    adj_valid,
  output adj_vec_t                adj_data
);

  adj_vec_t                ia_adj;
  logic signed [ACC_W-1:0] ia_sum [LANES];

  // activation zero-point, added per lane
  always_comb begin
    for (int j = 0; j < LANES; j++) begin
      ia_sum[j] = ACC_W'(ia_data[j]) + lhs_zp;
      ia_adj[j] = ADJ_W'(ia_sum[j]); // drop the unused upper bits
    end
  end

  // ====================
  // first pipeline register
  // ====================
  always_ff @(posedge clk) begin
    if (rst) begin
      adj_valid <= 1'b0;
    end else begin
      adj_valid <= ia_valid;
    end
  end

  // data only moves on a valid vector
  always_ff @(posedge clk) begin
    if (ia_valid) begin
      for (int j = 0; j < LANES; j++) begin
        adj_data[j] <= ia_adj[j];
      end
    end
  end

endmodule

`default_nettype wire

// ==== mma_weight_bank.sv ====
// rhs_zp is folded in at write time, so rows must be reloaded after rhs_zp changes
`timescale 1ns/10ps
`default_nettype none

module mma_weight_bank
  import mma_pkg::*;
(
  input  wire                            clk,
  input  wire                            rst,
  input  wire                            w_load,       // one-cycle write strobe
  input  lane_t                          w_row,        // output channel being written
  input  logic signed [W_W-1:0]          w_data [LANES],
  input  logic signed [ACC_W-1:0]        w_bias,
  input  logic signed [ACC_W-1:0]        rhs_zp,
  output adj_vec_t                       w_adj [LANES], // row r feeds channel r
  output logic signed [ACC_W-1:0]        bias [LANES]
);

  // incoming row with the weight zero-point applied
  adj_vec_t                row_adj;
  logic signed [ACC_W-1:0] row_sum [LANES];

  always_comb begin
    for (int j = 0; j < LANES; j++) begin
      row_sum[j] = ACC_W'(w_data[j]) + rhs_zp; // s8 + s32, wraps
      row_adj[j] = ADJ_W'(row_sum[j]);          // fits once zp is in range
    end
  end

  // ====================
  // storage
  // ====================
  // every row is visible at once, the dot array reads them combinationally
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < LANES; r++) begin
        bias[r] <= '0;
        for (int j = 0; j < LANES; j++) begin
          w_adj[r][j] <= '0;
        end
      end
    end else if (w_load) begin
      bias[w_row] <= w_bias; // channel bias travels with its row
      for (int j = 0; j < LANES; j++) begin
        w_adj[w_row][j] <= row_adj[j];
      end
    end
  end

endmodule

`default_nettype wire

// ==== mma_pkg.sv ====
// lane count and widths are fixed here; adjusted elements assume zero-points within +/-128
`default_nettype none

package mma_pkg;

  // ====================
  // array geometry
  // ====================
  localparam int LANES = 4; // activation lanes == output channels

  // ====================
  // element widths
  // ====================
  localparam int IA_W    = 8;  // s8 activations
  localparam int W_W     = 8;  // s8 weights
  localparam int ADJ_W   = 10; // offset-adjusted element, guard bit included
  localparam int ACC_W   = 32; // accumulator, bias, zero-points
  localparam int PROD_W  = 64; // scaled product before the rounding shift
  localparam int SHIFT_W = 5;  // right shift 0..31
  localparam int OUT_W   = 8;  // s8 results

  // output saturation limits, held at accumulator width for the compare
  localparam logic signed [ACC_W-1:0] OUT_MAX = ACC_W'((1 << (OUT_W - 1)) - 1);
  localparam logic signed [ACC_W-1:0] OUT_MIN = ACC_W'(-(1 << (OUT_W - 1)));

  // ====================
  // shared types
  // ====================
  // row or lane index
  typedef logic [$clog2(LANES)-1:0] lane_t;

  // one vector of zero-point adjusted elements, element j belongs to lane j
  typedef logic signed [ADJ_W-1:0] adj_vec_t [LANES];

endpackage

`default_nettype wire
